/* verilog.f */
design/iob_apb_pkg.sv
design/iob2apb.sv
design/apb_decoder.sv
design/apb_regfile.sv
design/apb_wait_ram.sv
design/iob_apb_sys.sv
tb/iob_apb_sys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timing \
  -f verilog.f \
  --top-module iob_apb_sys_tb \
  -Mdir "$BUILD_DIR" \
  -o iob_apb_sys_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/iob_apb_sys_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tb/iob_apb_sys_tb.sv */
module iob_apb_sys_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import iob_apb_pkg::*;

  localparam int NREGS       = 8;
  localparam int RAM_AW      = 6;
  localparam int WAIT_STATES = 3;
  localparam int N_TXN       = 300;
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int WATCHDOG_CYCLES = N_TXN * (2 + WAIT_STATES + 10) + 50;

  logic  clk_i;
  logic  rst_n_i;
  logic  cke_i;
  logic  iob_avalid_i;
  addr_t iob_addr_i;
  data_t iob_wdata_i;
  strb_t iob_wstrb_i;
  logic  iob_ready_o;
  logic  iob_rvalid_o;
  data_t iob_rdata_o;

  // Reference model of both completers
  data_t reg_model [NREGS];
  data_t mem_model [2**RAM_AW];

  logic  busy;         // A transfer was accepted and has not completed
  int    cnt;          // Enabled edges since acceptance
  int    exp_lat;
  data_t exp_rdata;
  logic  exp_rvalid;
  logic  exp_ready;
  logic  prev_ready;
  logic  prev_rvalid;
  data_t prev_rdata;
  int    n_accepted;
  int    n_reg_reads;
  int    n_mem_reads;
  int    n_writes;

  logic  req_is_mem;
  int    req_reg_idx;
  int    req_mem_idx;
  data_t req_word;

  iob_apb_sys #(
    .NREGS       (NREGS),
    .RAM_AW      (RAM_AW),
    .WAIT_STATES (WAIT_STATES)
  ) iob_apb_sys_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cke_i        (cke_i),
    .iob_avalid_i (iob_avalid_i),
    .iob_addr_i   (iob_addr_i),
    .iob_wdata_i  (iob_wdata_i),
    .iob_wstrb_i  (iob_wstrb_i),
    .iob_ready_o  (iob_ready_o),
    .iob_rvalid_o (iob_rvalid_o),
    .iob_rdata_o  (iob_rdata_o)
  );

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < DATA_W/8; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic report_mismatch(input string sig, input data_t expected, input data_t actual);
    $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, sig, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "Output check failed");
  endtask

  task automatic report_failure(input string what);
    $display("Error at time %0t: %s", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "Run aborted");
  endtask

  assign req_is_mem  = iob_addr_i[SEL_BIT];
  assign req_reg_idx = int'(iob_addr_i[ADDR_W-1:2]) % NREGS;  // Register indices alias
  assign req_mem_idx = int'(iob_addr_i[RAM_AW+1:2]);
  assign req_word    = req_is_mem ? mem_model[req_mem_idx] : reg_model[req_reg_idx];
  assign exp_rvalid  = busy && (cnt == exp_lat);
  assign exp_ready   = !busy || exp_rvalid;

  // Tracks each request from acceptance to the expected rvalid edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy        <= 1'b0;
      cnt         <= 0;
      exp_lat     <= 0;
      exp_rdata   <= '0;
      prev_ready  <= 1'b1;
      prev_rvalid <= 1'b0;
      prev_rdata  <= '0;
      n_accepted  <= 0;
      n_reg_reads <= 0;
      n_mem_reads <= 0;
      n_writes    <= 0;
      for (int i = 0; i < NREGS; i++) begin
        reg_model[i] <= '0;
      end
      for (int i = 0; i < 2**RAM_AW; i++) begin
        mem_model[i] <= '0;
      end
    end else begin
      prev_ready  <= iob_ready_o;
      prev_rvalid <= iob_rvalid_o;
      prev_rdata  <= iob_rdata_o;
      if (cke_i) begin
        if (iob_avalid_i && exp_ready) begin
          busy       <= 1'b1;
          cnt        <= 0;
          exp_lat    <= req_is_mem ? 2 + WAIT_STATES : 2;
          n_accepted <= n_accepted + 1;
          if (iob_wstrb_i == '0) begin
            exp_rdata <= req_word;
            if (req_is_mem) begin
              n_mem_reads <= n_mem_reads + 1;
            end else begin
              n_reg_reads <= n_reg_reads + 1;
            end
          end else begin
            exp_rdata <= '0;  // Writes answer with zero
            n_writes  <= n_writes + 1;
            if (req_is_mem) begin
              mem_model[req_mem_idx] <= merge_bytes(req_word, iob_wdata_i, iob_wstrb_i);
            end else begin
              reg_model[req_reg_idx] <= merge_bytes(req_word, iob_wdata_i, iob_wstrb_i);
            end
          end
        end else if (exp_rvalid) begin
          busy <= 1'b0;
        end else if (busy) begin
          cnt <= cnt + 1;
        end
      end
    end
  end

  a_reset_ready: assert property (@(posedge clk_i) !rst_n_i |=> iob_ready_o)
    else report_mismatch("iob_ready_o", data_t'(1'b1), data_t'($sampled(iob_ready_o)));
  a_reset_rvalid: assert property (@(posedge clk_i) !rst_n_i |=> !iob_rvalid_o)
    else report_mismatch("iob_rvalid_o", data_t'(1'b0), data_t'($sampled(iob_rvalid_o)));

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i) iob_ready_o == exp_ready)
    else report_mismatch("iob_ready_o", data_t'($sampled(exp_ready)),
                         data_t'($sampled(iob_ready_o)));
  // Covers latency, single pulse and no rvalid for ignored requests
  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    iob_rvalid_o == exp_rvalid)
    else report_mismatch("iob_rvalid_o", data_t'($sampled(exp_rvalid)),
                         data_t'($sampled(iob_rvalid_o)));
  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    iob_rvalid_o |-> iob_rdata_o == exp_rdata)
    else report_mismatch("iob_rdata_o", $sampled(exp_rdata), $sampled(iob_rdata_o));

  a_cke_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !cke_i |=> iob_ready_o == prev_ready)
    else report_mismatch("iob_ready_o", data_t'($sampled(prev_ready)),
                         data_t'($sampled(iob_ready_o)));
  a_cke_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !cke_i |=> iob_rvalid_o == prev_rvalid)
    else report_mismatch("iob_rvalid_o", data_t'($sampled(prev_rvalid)),
                         data_t'($sampled(iob_rvalid_o)));
  a_cke_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !cke_i |=> iob_rdata_o == prev_rdata)
    else report_mismatch("iob_rdata_o", $sampled(prev_rdata), $sampled(iob_rdata_o));

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before all transactions completed");
  end

  task automatic next_drive_slot();
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // New random request every cycle, also while the bridge is busy
  task automatic drive_random_inputs();
    cke_i        = ($urandom % 10) != 0;
    iob_avalid_i = ($urandom % 10) < 7;
    iob_addr_i   = ADDR_W'($urandom);
    iob_addr_i[SEL_BIT] = 1'($urandom % 2);
    iob_wdata_i  = $urandom;
    if (($urandom % 10) < 4) begin
      iob_wstrb_i = '0;
    end else begin
      iob_wstrb_i = strb_t'($urandom % 15 + 1);
    end
  endtask

  initial begin
    void'($urandom(32'hc833));
    rst_n_i      = 1'b0;
    cke_i        = 1'b1;
    iob_avalid_i = 1'b0;
    iob_addr_i   = '0;
    iob_wdata_i  = '0;
    iob_wstrb_i  = '0;
    repeat (2) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    while (n_accepted < N_TXN) begin
      drive_random_inputs();
      next_drive_slot();
    end
    iob_avalid_i = 1'b0;
    cke_i        = 1'b1;
    while (busy) begin
      next_drive_slot();
    end
    repeat (3) next_drive_slot();

    if (n_reg_reads > 0 && n_mem_reads > 0 && n_writes > 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_failure("traffic did not reach reads of both regions and writes");
    end
  end

endmodule

/* design/iob_apb_sys.sv */
module iob_apb_sys #(
  parameter int NREGS       = 8,
  parameter int RAM_AW      = 6,
  parameter int WAIT_STATES = 3
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cke_i,
  input  logic               iob_avalid_i,
  input  iob_apb_pkg::addr_t iob_addr_i,
  input  iob_apb_pkg::data_t iob_wdata_i,
  input  iob_apb_pkg::strb_t iob_wstrb_i,
  output logic               iob_ready_o,
  output logic               iob_rvalid_o,
  output iob_apb_pkg::data_t iob_rdata_o
);
  import iob_apb_pkg::*;

  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  apb_rsp_t reg_rsp;
  apb_rsp_t mem_rsp;
  logic     apb_sel;
  logic     apb_enable;
  logic     reg_sel;
  logic     mem_sel;

  iob2apb bridge_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cke_i        (cke_i),
    .iob_avalid_i (iob_avalid_i),
    .iob_addr_i   (iob_addr_i),
    .iob_wdata_i  (iob_wdata_i),
    .iob_wstrb_i  (iob_wstrb_i),
    .iob_ready_o  (iob_ready_o),
    .iob_rvalid_o (iob_rvalid_o),
    .iob_rdata_o  (iob_rdata_o),
    .apb_req_o    (apb_req),
    .apb_sel_o    (apb_sel),
    .apb_enable_o (apb_enable),
    .apb_rsp_i    (apb_rsp)
  );

  apb_decoder decoder_i (
    .apb_req_i    (apb_req),
    .apb_sel_i    (apb_sel),
    .apb_enable_i (apb_enable),
    .reg_rsp_i    (reg_rsp),
    .mem_rsp_i    (mem_rsp),
    .reg_sel_o    (reg_sel),
    .mem_sel_o    (mem_sel),
    .apb_rsp_o    (apb_rsp)
  );

  // Penable and request fields fan out to both completers
  apb_regfile #(
    .NREGS (NREGS)
  ) regfile_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cke_i     (cke_i),
    .psel_i    (reg_sel),
    .penable_i (apb_enable),
    .apb_req_i (apb_req),
    .apb_rsp_o (reg_rsp)
  );

  apb_wait_ram #(
    .RAM_AW      (RAM_AW),
    .WAIT_STATES (WAIT_STATES)
  ) ram_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cke_i     (cke_i),
    .psel_i    (mem_sel),
    .penable_i (apb_enable),
    .apb_req_i (apb_req),
    .apb_rsp_o (mem_rsp)
  );

endmodule

/* design/apb_wait_ram.sv */
module apb_wait_ram #(
  parameter int RAM_AW      = 6,
  parameter int WAIT_STATES = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cke_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  iob_apb_pkg::apb_req_t apb_req_i,
  output iob_apb_pkg::apb_rsp_t apb_rsp_o
);
  import iob_apb_pkg::*;

  localparam int DEPTH = 2 ** RAM_AW;
  localparam int CNT_W = $clog2(WAIT_STATES + 2);

  data_t              mem_q [DEPTH];
  logic [RAM_AW-1:0]  idx;
  logic [CNT_W-1:0]   wait_cnt_q;
  logic               access;
  logic               rdy;

  assign idx    = apb_req_i.addr[RAM_AW+1:2];
  assign access = psel_i && penable_i;
  assign rdy    = access && (wait_cnt_q == CNT_W'(WAIT_STATES));

  // Counts access cycles spent waiting
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_cnt_q <= '0;
    end else if (cke_i) begin
      if (!access || rdy) begin
        wait_cnt_q <= '0;  // Ready for the next transfer
      end else begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (cke_i && rdy && apb_req_i.write) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (apb_req_i.wstrb[b]) begin
          mem_q[idx][8*b +: 8] <= apb_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  assign apb_rsp_o.ready = rdy;
  assign apb_rsp_o.rdata = rdy ? mem_q[idx] : '0;  // Zero unless completing

  a_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_rsp_o.ready |-> (psel_i && penable_i))
    else $error("Memory ready outside the access phase");

endmodule

/* design/apb_regfile.sv */
module apb_regfile #(
  parameter int NREGS = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cke_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  iob_apb_pkg::apb_req_t apb_req_i,
  output iob_apb_pkg::apb_rsp_t apb_rsp_o
);
  import iob_apb_pkg::*;

  localparam int IDX_W = (NREGS > 1) ? $clog2(NREGS) : 1;

  data_t              regs_q [NREGS];
  logic [ADDR_W-3:0]  word_addr;
  logic [IDX_W-1:0]   idx;
  logic               access;

  assign word_addr = apb_req_i.addr[ADDR_W-1:2];  // Drop the byte offset
  assign idx       = IDX_W'(word_addr % NREGS);     // Indices alias past NREGS
  assign access    = psel_i && penable_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (cke_i && access && apb_req_i.write) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (apb_req_i.wstrb[b]) begin
          regs_q[idx][8*b +: 8] <= apb_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // No wait states
  assign apb_rsp_o.ready = access;
  assign apb_rsp_o.rdata = psel_i ? regs_q[idx] : '0;

endmodule

/* design/apb_decoder.sv */
module apb_decoder (
  input  iob_apb_pkg::apb_req_t apb_req_i,
  input  logic                  apb_sel_i,
  input  logic                  apb_enable_i,
  input  iob_apb_pkg::apb_rsp_t reg_rsp_i,
  input  iob_apb_pkg::apb_rsp_t mem_rsp_i,
  output logic                  reg_sel_o,
  output logic                  mem_sel_o,
  output iob_apb_pkg::apb_rsp_t apb_rsp_o
);
  import iob_apb_pkg::*;

  logic     mem_hit;
  apb_rsp_t sel_rsp;

  // One address bit splits the map in two regions
  assign mem_hit = apb_req_i.addr[SEL_BIT];

  assign reg_sel_o = apb_sel_i && !mem_hit;
  assign mem_sel_o = apb_sel_i && mem_hit;

  assign sel_rsp = mem_hit ? mem_rsp_i : reg_rsp_i;

  always_comb begin
    apb_rsp_o       = sel_rsp;
    // Ready only counts inside the access phase
    apb_rsp_o.ready = sel_rsp.ready && apb_sel_i && apb_enable_i;
  end

  always_comb begin
    a_sel_onehot: assert (!(reg_sel_o && mem_sel_o))
      else $error("Both completers selected");
  end

endmodule

/* design/iob2apb.sv */
module iob2apb (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cke_i,
  input  logic                  iob_avalid_i,
  input  iob_apb_pkg::addr_t    iob_addr_i,
  input  iob_apb_pkg::data_t    iob_wdata_i,
  input  iob_apb_pkg::strb_t    iob_wstrb_i,
  output logic                  iob_ready_o,
  output logic                  iob_rvalid_o,
  output iob_apb_pkg::data_t    iob_rdata_o,
  output iob_apb_pkg::apb_req_t apb_req_o,
  output logic                  apb_sel_o,
  output logic                  apb_enable_o,
  input  iob_apb_pkg::apb_rsp_t apb_rsp_i
);
  import iob_apb_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_t;

  state_t   state_q;
  state_t   state_d;
  apb_req_t req_q;
  apb_req_t req_d;
  logic     rvalid_q;
  logic     rvalid_d;
  data_t    rdata_q;
  data_t    rdata_d;
  logic     accept;

  assign accept = iob_avalid_i && iob_ready_o;  // Request taken at this edge

  always_comb begin
    state_d  = state_q;
    req_d    = req_q;
    rvalid_d = 1'b0;  // Pulse lasts one enabled cycle
    rdata_d  = rdata_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          req_d.addr  = iob_addr_i;
          req_d.write = (iob_wstrb_i != '0);
          req_d.wstrb = iob_wstrb_i;
          req_d.wdata = iob_wdata_i;
          state_d     = SETUP;
        end
      end
      SETUP: state_d = ACCESS;  // Setup phase is always one cycle
      ACCESS: begin
        if (apb_rsp_i.ready) begin
          // Writes return zero on the IOb side
          rdata_d  = req_q.write ? '0 : apb_rsp_i.rdata;
          rvalid_d = 1'b1;
          state_d  = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      req_q    <= '0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else if (cke_i) begin
      state_q  <= state_d;
      req_q    <= req_d;
      rvalid_q <= rvalid_d;
      rdata_q  <= rdata_d;
    end
  end

  assign iob_ready_o  = (state_q == IDLE);
  assign iob_rvalid_o = rvalid_q;
  assign iob_rdata_o  = rdata_q;
  assign apb_req_o    = req_q;
  assign apb_sel_o    = (state_q != IDLE);
  assign apb_enable_o = (state_q == ACCESS);

  a_enable_in_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_enable_o |-> apb_sel_o)
    else $error("apb_enable_o high without apb_sel_o");

  // Request fields must not move for the whole transfer
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_sel_o |=> (!apb_sel_o || $stable(apb_req_o)))
    else $error("apb_req_o changed during a transfer");

  a_rvalid_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cke_i && iob_rvalid_o) |=> !iob_rvalid_o)
    else $error("iob_rvalid_o high on two enabled cycles in a row");

endmodule

/* design/iob_apb_pkg.sv */
package iob_apb_pkg;

  parameter int ADDR_W  = 16;  // Byte address, IOb and APB
  parameter int DATA_W  = 32;
  parameter int SEL_BIT = 12;  // 0 picks the register bank, 1 the memory

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;  // All zero means a read

  // Request fields seen by every completer
  typedef struct packed {
    addr_t addr;
    logic  write;
    strb_t wstrb;
    data_t wdata;
  } apb_req_t;

  // Response of one completer
  typedef struct packed {
    data_t rdata;
    logic  ready;
  } apb_rsp_t;

endpackage
